// File: compile.f
rtl/fpmul_pkg.sv
rtl/fpmul_prep.sv
rtl/fpmul_execute.sv
rtl/fpmul_normalize.sv
rtl/fpmul_round.sv
rtl/fpmul_top.sv
verif/fpmul_checker.sv
verif/fpmul_tb.sv

// File: Makefile
TOP = fpmul_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/fpmul_tb.sv
`timescale 1ns/10ps

module fpmul_tb;
	import fpmul_pkg::*;

	localparam int n_random  = 300;
	localparam int n_special = 100;  // 10 x 10 operand grid
	localparam int n_range   = 40;
	localparam int n_round   = 64;   // 8 x 8 fraction grid
	localparam int n_stream  = 60;
	localparam int n_pairs   = n_random + n_special + n_range + n_round + n_stream;
	localparam int cycle_limit = 2 * n_pairs + 5 + 50;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic [31:0] a;
	logic [31:0] b;
	logic        out_valid;
	fpmul_out_t  out;
	int          cycles = 0;

	// Zeros, infinities, NaNs, subnormals, two normals
	logic [31:0] specials [10] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000,
		32'hff80_0000, 32'h7fc0_0000, 32'hff80_0001, 32'h0000_0001, 32'h8040_0000,
		32'h3f80_0000, 32'hc020_0000};
	// Exact, tie and carry fractions
	logic [22:0] fracs [8] = '{23'h00_0000, 23'h40_0000, 23'h00_0001, 23'h00_0003,
		23'h7f_ffff, 23'h7f_fffe, 23'h20_0001, 23'h60_0001};

	fpmul_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.out       (out)
	);

	fpmul_checker i_checker (
		.clk       (clk),
		.out_valid (out_valid),
		.out       (out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	task automatic model_mul(input logic [31:0] x, input logic [31:0] y,
		output fpmul_out_t r);
		int          ex;
		int          ey;
		int          e;
		logic        sign, zx, zy, ix, iy, nx, ny, lost_lsb, up;
		logic [47:0] p;
		logic [24:0] m;     // Top bit takes the rounding carry
		logic [22:0] rem;   // Bits below the kept mantissa
		ex   = int'(x[30:23]);
		ey   = int'(y[30:23]);
		sign = x[31] ^ y[31];
		zx   = (ex == 0);  // Subnormal counts as zero
		zy   = (ey == 0);
		ix   = (ex == 255) && (x[22:0] == 0);
		iy   = (ey == 255) && (y[22:0] == 0);
		nx   = (ex == 255) && (x[22:0] != 0);
		ny   = (ey == 255) && (y[22:0] != 0);
		r    = '0;
		if (nx || ny || (zx && iy) || (zy && ix)) begin
			r.result        = 32'h7fc0_0000;
			r.flags.invalid = 1'b1;
		end else if (ix || iy) begin
			r.result = {sign, 8'hff, 23'd0};
		end else if (zx || zy) begin
			r.result = {sign, 31'd0};
		end else begin
			p        = 48'({1'b1, x[22:0]}) * 48'({1'b1, y[22:0]});
			e        = ex + ey - 127;
			lost_lsb = 1'b0;
			if (p[47]) begin  // Product in [2,4)
				lost_lsb = p[0];
				p        = p >> 1;
				e        = e + 1;
			end
			m   = {1'b0, p[46:23]};
			rem = p[22:0];
			// Past half, or exactly half with an odd lsb
			up  = (rem > 23'h40_0000) || ((rem == 23'h40_0000) && (lost_lsb || m[0]));
			m   = m + 25'(up);
			if (m[24]) begin
				m = m >> 1;
				e = e + 1;
			end
			if (e >= 255) begin
				r.result         = {sign, 8'hff, 23'd0};
				r.flags.overflow = 1'b1;
				r.flags.inexact  = 1'b1;
			end else if (e <= 0) begin
				r.result          = {sign, 31'd0};
				r.flags.underflow = 1'b1;
				r.flags.inexact   = 1'b1;
			end else begin
				r.result        = {sign, 8'(e), m[22:0]};
				r.flags.inexact = (rem != 0) || lost_lsb;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	// Random sign and fraction, exponent field in lo..hi
	function automatic logic [31:0] random_word(input int lo, input int hi);
		logic [31:0] w;
		w        = $urandom;
		w[30:23] = 8'($urandom_range(hi, lo));
		return w;
	endfunction

	task automatic issue_pair(input string name, input logic [31:0] x, input logic [31:0] y);
		fpmul_out_t expd;
		model_mul(x, y, expd);
		i_checker.push_expected(name, expd);
		in_valid = 1'b1;
		a        = x;
		b        = y;
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		@(posedge clk);
		#1;
	endtask

	// Drain the pipe, then one line for the test
	task automatic finish_test(input string name);
		in_valid = 1'b0;
		while (i_checker.pending() != 0)
			@(posedge clk);
		@(posedge clk);
		#1;
		i_checker.report_test(name);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		int dropped;
		rst      = 1'b1;
		in_valid = 1'b0;
		a        = '0;
		b        = '0;
		void'($urandom(32'h7351d66e));
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < n_random; i++)
			issue_pair("random", random_word(64, 190), random_word(64, 190));
		finish_test("random");

		for (int i = 0; i < 10; i++)
			for (int j = 0; j < 10; j++)
				issue_pair("special", specials[i], specials[j]);
		finish_test("special");

		for (int i = 0; i < n_range / 2; i++) begin
			issue_pair("range", random_word(192, 254), random_word(192, 254));  // Too big
			issue_pair("range", random_word(1, 60), random_word(1, 60));        // Too small
		end
		finish_test("range");

		for (int i = 0; i < 8; i++)
			for (int j = 0; j < 8; j++)
				issue_pair("rounding", {1'($urandom_range(1, 0)), 8'd127, fracs[i]},
					{1'($urandom_range(1, 0)), 8'd127, fracs[j]});
		finish_test("rounding");

		// First half with random gaps, reset while busy
		for (int i = 0; i < n_stream / 2; i++) begin
			issue_pair("stream", random_word(64, 190), random_word(64, 190));
			if ($urandom_range(1, 0) == 1)
				idle_cycle();
		end
		in_valid = 1'b0;
		rst      = 1'b1;
		@(posedge clk);
		#1;
		dropped = i_checker.drop_pending();
		$display("mid-run reset dropped %0d pairs in flight", dropped);
		repeat (3) begin
			if (out_valid !== 1'b0)
				i_checker.note_failure("out_valid still high after mid-run reset");
			@(posedge clk);
			#1;
		end
		rst = 1'b0;
		for (int i = 0; i < n_stream / 2; i++)  // Back to back
			issue_pair("stream", random_word(64, 190), random_word(64, 190));
		finish_test("stream");

		i_checker.final_check();
		if (i_checker.total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: verif/fpmul_checker.sv
`timescale 1ns/10ps

module fpmul_checker (
	input logic                  clk,
	input logic                  out_valid,
	input fpmul_pkg::fpmul_out_t out
);
	import fpmul_pkg::*;

	fpmul_out_t exp_q[$];   // Expected results, issue order
	string      name_q[$];  // Test name per entry
	fpmul_out_t expd;
	string      expd_name;
	int         test_checks  = 0;
	int         test_errors  = 0;
	int         total_checks = 0;
	int         total_errors = 0;

	//////////////////////////////////////////////////
	// Queue access from the testbench
	//////////////////////////////////////////////////
	function automatic void push_expected(input string name, input fpmul_out_t val);
		exp_q.push_back(val);
		name_q.push_back(name);
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	// Pairs in flight at a reset never come out
	function automatic int drop_pending();
		int n;
		n = exp_q.size();
		exp_q.delete();
		name_q.delete();
		return n;
	endfunction

	function automatic void note_failure(input string msg);
		$display("ERROR: %s", msg);
		test_errors++;
		total_errors++;
	endfunction

	function automatic void report_test(input string name);
		$display("test %-9s done: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endfunction

	function automatic void final_check();
		if (exp_q.size() != 0)
			note_failure($sformatf("%0d expected results never came out", exp_q.size()));
		$display("totals: %0d checks, %0d errors", total_checks, total_errors);
	endfunction

	//////////////////////////////////////////////////
	// Compare on the falling edge, outputs settled
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				note_failure("out_valid high with no result expected");
			end else begin
				expd      = exp_q.pop_front();
				expd_name = name_q.pop_front();
				test_checks++;
				total_checks++;
				if (out !== expd) begin  // Result and flags together
					$display("CHECK FAILED %s: expected %h flags %b, actual %h flags %b",
						expd_name, expd.result, expd.flags, out.result, out.flags);
					test_errors++;
					total_errors++;
				end
			end
		end
	end

endmodule

// File: rtl/fpmul_top.sv
`timescale 1ns/10ps

module fpmul_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  logic [31:0]           a,
	input  logic [31:0]           b,
	output logic                  out_valid,
	output fpmul_pkg::fpmul_out_t out
);
	import fpmul_pkg::*;

	// Raw input pair
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
	} in_pair_t;

	in_pair_t    pipe_0;  // Input -> prep
	prep_stage_t pipe_1;  // Prep -> execute
	exec_stage_t pipe_2;  // Execute -> normalize
	norm_stage_t pipe_3;  // Normalize -> round
	fpmul_out_t  pipe_4;  // Round -> output
	logic [4:0]  valid;   // Bit i follows pipe_i

	prep_stage_t prep_ops;
	exec_stage_t exec_prod;
	norm_stage_t norm_res;
	fpmul_out_t  round_res;

	//////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////
	fpmul_prep i_prep (
		.a   (pipe_0.a),
		.b   (pipe_0.b),
		.ops (prep_ops)
	);

	fpmul_execute i_execute (
		.ops  (pipe_1),
		.prod (exec_prod)
	);

	fpmul_normalize i_normalize (
		.prod (pipe_2),
		.norm (norm_res)
	);

	fpmul_round i_round (
		.norm (pipe_3),
		.res  (round_res)
	);

	//////////////////////////////////////////////////
	// Pipeline registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			valid  <= '0;  // Drops everything in flight
			pipe_0 <= '0;
			pipe_1 <= '0;
			pipe_2 <= '0;
			pipe_3 <= '0;
			pipe_4 <= '0;
		end else begin
			valid    <= {valid[3:0], in_valid};  // No stall, always advances
			pipe_0.a <= a;
			pipe_0.b <= b;
			pipe_1   <= prep_ops;
			pipe_2   <= exec_prod;
			pipe_3   <= norm_res;
			pipe_4   <= round_res;
		end
	end

	assign out_valid = valid[4];
	assign out       = pipe_4;

	// Strobe must be clean once out of reset
	a_out_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(out_valid))
		else $error("out_valid unknown after reset");

endmodule

// File: rtl/fpmul_round.sv
`timescale 1ns/10ps

module fpmul_round (
	input  fpmul_pkg::norm_stage_t norm,
	output fpmul_pkg::fpmul_out_t  res
);
	import fpmul_pkg::*;

	logic                    round_up;  // RNE decision
	logic [frac_w:0]         man_rnd;   // Extra bit catches the carry
	logic signed [exp_w+1:0] exp_rnd;
	logic                    lost;      // Any discarded bit
	logic                    any_nan;
	logic                    any_inf;
	logic                    any_zero;

	//////////////////////////////////////////////////
	// Round to nearest even
	//////////////////////////////////////////////////
	assign round_up = norm.guard & (norm.round | norm.sticky | norm.man[0]);
	assign man_rnd  = {1'b0, norm.man} + (frac_w+1)'(round_up);
	// All-ones fraction wraps to zero, exponent steps up
	assign exp_rnd  = norm.exp + $signed({{(exp_w+1){1'b0}}, man_rnd[frac_w]});
	assign lost     = norm.guard | norm.round | norm.sticky;

	assign any_nan  = (norm.cls_a == class_nan) || (norm.cls_b == class_nan);
	assign any_inf  = (norm.cls_a == class_inf) || (norm.cls_b == class_inf);
	assign any_zero = (norm.cls_a == class_zero) || (norm.cls_b == class_zero);

	//////////////////////////////////////////////////
	// Specials, saturation, packing
	//////////////////////////////////////////////////
	always_comb begin
		res.flags = '0;
		if (any_nan || (any_inf && any_zero)) begin
			res.result        = qnan;  // 0 x inf lands here too
			res.flags.invalid = 1'b1;
		end else if (any_inf) begin
			res.result = {norm.sign, {exp_w{1'b1}}, {frac_w{1'b0}}};
		end else if (any_zero) begin
			res.result = {norm.sign, 31'b0};  // Exact signed zero
		end else if (int'(exp_rnd) >= (2**exp_w) - 1) begin
			// Past the largest finite exponent
			res.result         = {norm.sign, {exp_w{1'b1}}, {frac_w{1'b0}}};
			res.flags.overflow = 1'b1;
			res.flags.inexact  = 1'b1;
		end else if (int'(exp_rnd) <= 0) begin
			// Subnormal range flushes
			res.result          = {norm.sign, 31'b0};
			res.flags.underflow = 1'b1;
			res.flags.inexact   = 1'b1;
		end else begin
			res.result        = {norm.sign, exp_rnd[exp_w-1:0], man_rnd[frac_w-1:0]};
			res.flags.inexact = lost;
		end
	end

endmodule

// File: rtl/fpmul_normalize.sv
`timescale 1ns/10ps

module fpmul_normalize (
	input  fpmul_pkg::exec_stage_t prod,
	output fpmul_pkg::norm_stage_t norm
);
	import fpmul_pkg::*;

	logic top;  // Product in [2,4)

	assign top = prod.prod[2*man_w-1];

	always_comb begin
		norm.sign  = prod.sign;
		norm.cls_a = prod.cls_a;
		norm.cls_b = prod.cls_b;
		if (top) begin
			// Leading one at 47, shift right by one
			norm.exp    = prod.exp + (exp_w+2)'(1);
			norm.man    = prod.prod[46:24];
			norm.guard  = prod.prod[23];
			norm.round  = prod.prod[22];
			norm.sticky = |prod.prod[21:0];
		end else begin
			// Leading one at 46, already in place
			norm.exp    = prod.exp;
			norm.man    = prod.prod[45:23];
			norm.guard  = prod.prod[22];
			norm.round  = prod.prod[21];
			norm.sticky = |prod.prod[20:0];
		end
	end

endmodule

// File: rtl/fpmul_execute.sv
`timescale 1ns/10ps

module fpmul_execute (
	input  fpmul_pkg::prep_stage_t ops,
	output fpmul_pkg::exec_stage_t prod
);
	import fpmul_pkg::*;

	logic signed [exp_w+1:0] exp_a;  // Zero-extended, room for the sum
	logic signed [exp_w+1:0] exp_b;

	assign exp_a = $signed({2'b00, ops.a_op.exp});
	assign exp_b = $signed({2'b00, ops.b_op.exp});

	always_comb begin
		prod.sign  = ops.a_op.sign ^ ops.b_op.sign;  // Holds for specials too
		// Biased sum, can go negative on small operands
		prod.exp   = exp_a + exp_b - (exp_w+2)'(exp_bias);
		// 24x24 into 48 bits
		prod.prod  = ops.a_op.man * ops.b_op.man;
		prod.cls_a = ops.a_op.cls;  // Classes ride along to rounding
		prod.cls_b = ops.b_op.cls;
	end

endmodule

// File: rtl/fpmul_prep.sv
`timescale 1ns/10ps

module fpmul_prep (
	input  logic [31:0]            a,
	input  logic [31:0]            b,
	output fpmul_pkg::prep_stage_t ops
);
	import fpmul_pkg::*;

	// Split one word and classify it
	function automatic fp_operand_t unpack(input logic [31:0] w);
		fp_operand_t       op;
		logic [exp_w-1:0]  e;
		logic [frac_w-1:0] f;
		e       = w[frac_w +: exp_w];
		f       = w[frac_w-1:0];
		op.sign = w[31];
		op.exp  = e;
		if (e == '0) begin
			// Subnormals flush to zero, fraction dropped
			op.man = '0;
			op.cls = class_zero;
		end else if (e == '1) begin
			op.man = {1'b1, f};
			op.cls = (f != '0) ? class_nan : class_inf;
		end else begin
			op.man = {1'b1, f};  // Restore hidden one
			op.cls = class_norm;
		end
		return op;
	endfunction

	always_comb begin
		ops.a_op = unpack(a);
		ops.b_op = unpack(b);
	end

endmodule

// File: rtl/fpmul_pkg.sv
package fpmul_pkg;

	//////////////////////////////////////////////////
	// Single-precision format
	//////////////////////////////////////////////////
	localparam int exp_w    = 8;                    // Exponent field
	localparam int frac_w   = 23;                   // Stored fraction
	localparam int man_w    = 24;                   // Fraction plus hidden one
	localparam int exp_bias = 127;
	localparam logic [31:0] qnan = 32'h7fc0_0000;   // Canonical quiet NaN

	// Operand class after unpacking
	typedef enum logic [1:0] {
		class_zero,  // Zero or flushed subnormal
		class_norm,
		class_inf,
		class_nan
	} fp_class_e;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fp_flags_t;

	typedef struct packed {
		logic             sign;
		logic [exp_w-1:0] exp;
		logic [man_w-1:0] man;  // Hidden bit on top
		fp_class_e        cls;
	} fp_operand_t;

	//////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////
	typedef struct packed {
		fp_operand_t a_op;
		fp_operand_t b_op;
	} prep_stage_t;

	typedef struct packed {
		logic                    sign;
		logic signed [exp_w+1:0] exp;   // ea + eb - bias
		logic [2*man_w-1:0]      prod;  // Raw significand product
		fp_class_e               cls_a;
		fp_class_e               cls_b;
	} exec_stage_t;

	typedef struct packed {
		logic                    sign;
		logic signed [exp_w+1:0] exp;
		logic [frac_w-1:0]       man;   // Fraction below the leading one
		logic                    guard;
		logic                    round;
		logic                    sticky;
		fp_class_e               cls_a;
		fp_class_e               cls_b;
	} norm_stage_t;

	typedef struct packed {
		logic [31:0] result;
		fp_flags_t   flags;
	} fpmul_out_t;

endpackage
